// File: hw/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // framing state of the ingress path
    typedef enum logic [1:0] {
        IDLE    = 2'd0, // between packets
        PASS    = 2'd1, // inside a packet, forwarding
        DISCARD = 2'd2  // cut packet, dropping up to its last beat
    } frame_state_t;

    // verdict on the beat at the head of the slice
    typedef enum logic [1:0] {
        OP_FWD  = 2'd0, // forward unchanged
        OP_CUT  = 2'd1, // forward with last and full keep
        OP_DROP = 2'd2  // swallow
    } gate_op_t;

endpackage

`default_nettype wire

// File: hw/stream_reg.sv
`default_nettype none

module stream_reg #(
    parameter int TDATA_WIDTH = 32,
    parameter int TUSER_WIDTH = 8,
    parameter int TKEEP_WIDTH = TDATA_WIDTH / 8,
    parameter int MODE        = 0,
    parameter int NUM_LEVELS  = 1
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    s_tvalid,
    output logic                   s_tready,
    input  wire                    s_tstart,
    input  wire                    s_tlast,
    input  wire  [TKEEP_WIDTH-1:0] s_tkeep,
    input  wire  [TUSER_WIDTH-1:0] s_tuser,
    input  wire  [TDATA_WIDTH-1:0] s_tdata,
    output logic                   in_reg_tvalid,
    input  wire                    in_reg_tready,
    output logic                   in_reg_tstart,
    output logic                   in_reg_tlast,
    output logic [TKEEP_WIDTH-1:0] in_reg_tkeep,
    output logic [TUSER_WIDTH-1:0] in_reg_tuser,
    output logic [TDATA_WIDTH-1:0] in_reg_tdata
);
    localparam int PW = TUSER_WIDTH + TDATA_WIDTH + TKEEP_WIDTH + 2; // start, last, keep, user, data

    wire          vld [0:NUM_LEVELS]; // index i feeds stage i
    wire          rdy [0:NUM_LEVELS];
    wire [PW-1:0] pay [0:NUM_LEVELS];

    assign vld[0]          = s_tvalid;
    assign pay[0]          = {s_tstart, s_tlast, s_tkeep, s_tuser, s_tdata};
    assign s_tready        = rdy[0];
    assign rdy[NUM_LEVELS] = in_reg_tready;

    for (genvar i = 0; i < NUM_LEVELS; i++) begin : g_stage
        if (MODE == 0) begin : g_skid
            logic          main_vld;
            logic          skid_vld;
            logic          rdy_q;
            logic          main_vld_nxt;
            logic          skid_vld_nxt;
            logic          load_main;
            logic          load_skid;
            logic [PW-1:0] main_dat;
            logic [PW-1:0] skid_dat;

            always_comb begin
                main_vld_nxt = main_vld;
                skid_vld_nxt = skid_vld;
                load_main    = 1'b0;
                load_skid    = 1'b0;
                if (rdy[i+1] || !main_vld) begin
                    main_vld_nxt = skid_vld || (vld[i] && rdy_q); // skid drains first
                    skid_vld_nxt = 1'b0;
                    load_main    = skid_vld || (vld[i] && rdy_q);
                end else if (vld[i] && rdy_q) begin
                    skid_vld_nxt = 1'b1; // main is stalled, park the beat
                    load_skid    = 1'b1;
                end
            end

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    main_vld <= 1'b0;
                    skid_vld <= 1'b0;
                    rdy_q    <= 1'b0;
                end else begin
                    main_vld <= main_vld_nxt;
                    skid_vld <= skid_vld_nxt;
                    rdy_q    <= !skid_vld_nxt; // registered ready
                end
            end

            always_ff @(posedge clk) begin
                if (load_main) begin
                    main_dat <= skid_vld ? skid_dat : pay[i];
                end
                if (load_skid) begin
                    skid_dat <= pay[i];
                end
            end

            assign rdy[i]   = rdy_q;
            assign vld[i+1] = main_vld;
            assign pay[i+1] = main_dat;
        end else begin : g_fwd
            logic          vld_q;
            logic [PW-1:0] dat_q;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    vld_q <= 1'b0;
                end else if (rdy[i]) begin
                    vld_q <= vld[i];
                end
            end

            always_ff @(posedge clk) begin
                if (vld[i] && rdy[i]) begin
                    dat_q <= pay[i];
                end
            end

            assign rdy[i]   = rdy[i+1] || !vld_q; // ready is combinational here
            assign vld[i+1] = vld_q;
            assign pay[i+1] = dat_q;
        end
    end

    assign in_reg_tvalid = vld[NUM_LEVELS];
    // payload reads zero whenever the head is empty
    assign in_reg_tstart = in_reg_tvalid ? pay[NUM_LEVELS][PW-1] : 1'b0;
    assign in_reg_tlast  = in_reg_tvalid ? pay[NUM_LEVELS][PW-2] : 1'b0;
    assign in_reg_tkeep  = in_reg_tvalid ?
        pay[NUM_LEVELS][PW-3 -: TKEEP_WIDTH] : '0;
    assign in_reg_tuser  = in_reg_tvalid ?
        pay[NUM_LEVELS][TDATA_WIDTH +: TUSER_WIDTH] : '0;
    assign in_reg_tdata  = in_reg_tvalid ? pay[NUM_LEVELS][TDATA_WIDTH-1:0] : '0;

    // a stalled head beat must not change under the consumer
    a_head_stable: assert property (@(posedge clk) disable iff (!arst_n)
        in_reg_tvalid && !in_reg_tready |=> in_reg_tvalid && $stable(pay[NUM_LEVELS]));

endmodule

`default_nettype wire

// File: hw/beat_counter.sv
`default_nettype none

module beat_counter #(
    parameter int MAX_BEATS = 4
) (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  cnt_clear,
    input  wire  cnt_inc,
    output logic at_limit
);
    localparam int CW = $clog2(MAX_BEATS + 1);

    logic [CW-1:0] count; // beats accepted so far in this packet

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (cnt_clear) begin
            count <= cnt_inc ? CW'(1) : '0; // start beat counts as the first
        end else if (cnt_inc && count != CW'(MAX_BEATS)) begin
            count <= count + 1'b1; // saturates
        end
    end

    // head beat is number count+1
    assign at_limit = (count == CW'(MAX_BEATS - 1));

    // the framing FSM clears the count on the limit beat before it can reach MAX_BEATS
    a_count_range: assert property (@(posedge clk) disable iff (!arst_n)
        count < MAX_BEATS);

endmodule

`default_nettype wire

// File: hw/frame_fsm.sv
`default_nettype none

module frame_fsm (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  in_reg_tvalid,
    input  wire                  in_reg_tready,
    input  wire                  in_reg_tstart,
    input  wire                  in_reg_tlast,
    input  wire                  at_limit,
    output stream_pkg::gate_op_t beat_op,
    output logic                 cnt_clear,
    output logic                 cnt_inc
);
    stream_pkg::frame_state_t state;
    stream_pkg::frame_state_t state_nxt;
    logic                     xfer;

    assign xfer = in_reg_tvalid && in_reg_tready; // head beat leaves the slice

    always_comb begin
        beat_op   = stream_pkg::OP_DROP;
        state_nxt = state;
        cnt_clear = 1'b0;
        cnt_inc   = 1'b0;
        case (state)
            stream_pkg::IDLE,
            stream_pkg::PASS: begin
                if (in_reg_tstart) begin
                    // opens a packet, and closes one left open
                    beat_op   = stream_pkg::OP_FWD;
                    cnt_clear = xfer;
                    cnt_inc   = xfer && !in_reg_tlast;
                    state_nxt = in_reg_tlast ? stream_pkg::IDLE : stream_pkg::PASS;
                end else if (state == stream_pkg::PASS) begin
                    if (in_reg_tlast) begin
                        beat_op   = stream_pkg::OP_FWD;
                        cnt_clear = xfer;
                        state_nxt = stream_pkg::IDLE;
                    end else if (at_limit) begin
                        beat_op   = stream_pkg::OP_CUT; // too long, close it here
                        cnt_clear = xfer;
                        state_nxt = stream_pkg::DISCARD;
                    end else begin
                        beat_op = stream_pkg::OP_FWD;
                        cnt_inc = xfer;
                    end
                end
                // non-start beat in IDLE is an orphan and stays OP_DROP
            end
            stream_pkg::DISCARD: begin
                if (in_reg_tlast) begin
                    state_nxt = stream_pkg::IDLE; // tail of the cut packet
                end
            end
            default: begin
                state_nxt = stream_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= stream_pkg::IDLE;
        end else if (xfer) begin
            state <= state_nxt;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!arst_n)
        state inside {stream_pkg::IDLE, stream_pkg::PASS, stream_pkg::DISCARD});

endmodule

`default_nettype wire

// File: hw/frame_gate.sv
`default_nettype none

module frame_gate #(
    parameter int TDATA_WIDTH = 32,
    parameter int TUSER_WIDTH = 8,
    parameter int TKEEP_WIDTH = TDATA_WIDTH / 8,
    parameter int CNT_WIDTH   = 16
) (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       in_reg_tvalid,
    output logic                      in_reg_tready,
    input  wire                       in_reg_tlast,
    input  wire     [TKEEP_WIDTH-1:0] in_reg_tkeep,
    input  wire     [TUSER_WIDTH-1:0] in_reg_tuser,
    input  wire     [TDATA_WIDTH-1:0] in_reg_tdata,
    input  wire stream_pkg::gate_op_t beat_op,
    output logic                      m_tvalid,
    input  wire                       m_tready,
    output logic                      m_tlast,
    output logic    [TKEEP_WIDTH-1:0] m_tkeep,
    output logic    [TUSER_WIDTH-1:0] m_tuser,
    output logic    [TDATA_WIDTH-1:0] m_tdata,
    output logic      [CNT_WIDTH-1:0] pkt_count,
    output logic      [CNT_WIDTH-1:0] drop_count
);
    logic can_load;
    logic take;
    logic fwd;
    logic cut;

    assign can_load      = !m_tvalid || m_tready; // output register free next edge
    assign in_reg_tready = can_load || (beat_op == stream_pkg::OP_DROP); // drops never wait
    assign take          = in_reg_tvalid && in_reg_tready;
    assign fwd           = take && (beat_op != stream_pkg::OP_DROP);
    assign cut           = (beat_op == stream_pkg::OP_CUT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid <= 1'b0;
        end else if (can_load) begin
            m_tvalid <= fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            m_tlast <= in_reg_tlast || cut;
            m_tkeep <= cut ? {TKEEP_WIDTH{1'b1}} : in_reg_tkeep;
            m_tuser <= in_reg_tuser;
            m_tdata <= in_reg_tdata;
        end
    end

    // statistics
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_count  <= '0;
            drop_count <= '0;
        end else begin
            if (m_tvalid && m_tready && m_tlast) begin
                pkt_count <= pkt_count + 1'b1; // packet fully handed out
            end
            if (take && !fwd) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // empty beats must not escape, upstream keep plus cut forcing should cover it
    a_keep_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        m_tvalid |-> m_tkeep != '0);

endmodule

`default_nettype wire

// File: hw/pkt_ingress_top.sv
`default_nettype none

module pkt_ingress_top #(
    parameter int TDATA_WIDTH = 32,
    parameter int TUSER_WIDTH = 8,
    parameter int TKEEP_WIDTH = TDATA_WIDTH / 8,
    parameter int NUM_LEVELS  = 2,
    parameter int MODE        = 0,
    parameter int MAX_BEATS   = 4,
    parameter int CNT_WIDTH   = 16
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    s_tvalid,
    output logic                   s_tready,
    input  wire                    s_tstart,
    input  wire                    s_tlast,
    input  wire  [TKEEP_WIDTH-1:0] s_tkeep,
    input  wire  [TUSER_WIDTH-1:0] s_tuser,
    input  wire  [TDATA_WIDTH-1:0] s_tdata,
    output logic                   m_tvalid,
    input  wire                    m_tready,
    output logic                   m_tlast,
    output logic [TKEEP_WIDTH-1:0] m_tkeep,
    output logic [TUSER_WIDTH-1:0] m_tuser,
    output logic [TDATA_WIDTH-1:0] m_tdata,
    output logic   [CNT_WIDTH-1:0] pkt_count,
    output logic   [CNT_WIDTH-1:0] drop_count
);
    logic                     in_reg_tvalid;
    logic                     in_reg_tready;
    logic                     in_reg_tstart;
    logic                     in_reg_tlast;
    logic   [TKEEP_WIDTH-1:0] in_reg_tkeep;
    logic   [TUSER_WIDTH-1:0] in_reg_tuser;
    logic   [TDATA_WIDTH-1:0] in_reg_tdata;
    stream_pkg::gate_op_t     beat_op;
    logic                     cnt_clear;
    logic                     cnt_inc;
    logic                     at_limit;

    stream_reg #(
        .TDATA_WIDTH (TDATA_WIDTH),
        .TUSER_WIDTH (TUSER_WIDTH),
        .TKEEP_WIDTH (TKEEP_WIDTH),
        .MODE        (MODE),
        .NUM_LEVELS  (NUM_LEVELS)
    ) u_stream_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .s_tstart      (s_tstart),
        .s_tlast       (s_tlast),
        .s_tkeep       (s_tkeep),
        .s_tuser       (s_tuser),
        .s_tdata       (s_tdata),
        .in_reg_tvalid (in_reg_tvalid),
        .in_reg_tready (in_reg_tready),
        .in_reg_tstart (in_reg_tstart),
        .in_reg_tlast  (in_reg_tlast),
        .in_reg_tkeep  (in_reg_tkeep),
        .in_reg_tuser  (in_reg_tuser),
        .in_reg_tdata  (in_reg_tdata)
    );

    frame_fsm u_frame_fsm (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_reg_tvalid (in_reg_tvalid),
        .in_reg_tready (in_reg_tready),
        .in_reg_tstart (in_reg_tstart),
        .in_reg_tlast  (in_reg_tlast),
        .at_limit      (at_limit),
        .beat_op       (beat_op),
        .cnt_clear     (cnt_clear),
        .cnt_inc       (cnt_inc)
    );

    beat_counter #(
        .MAX_BEATS (MAX_BEATS)
    ) u_beat_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .cnt_clear (cnt_clear),
        .cnt_inc   (cnt_inc),
        .at_limit  (at_limit)
    );

    frame_gate #(
        .TDATA_WIDTH (TDATA_WIDTH),
        .TUSER_WIDTH (TUSER_WIDTH),
        .TKEEP_WIDTH (TKEEP_WIDTH),
        .CNT_WIDTH   (CNT_WIDTH)
    ) u_frame_gate (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_reg_tvalid (in_reg_tvalid),
        .in_reg_tready (in_reg_tready),
        .in_reg_tlast  (in_reg_tlast),
        .in_reg_tkeep  (in_reg_tkeep),
        .in_reg_tuser  (in_reg_tuser),
        .in_reg_tdata  (in_reg_tdata),
        .beat_op       (beat_op),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tlast       (m_tlast),
        .m_tkeep       (m_tkeep),
        .m_tuser       (m_tuser),
        .m_tdata       (m_tdata),
        .pkt_count     (pkt_count),
        .drop_count    (drop_count)
    );

endmodule

`default_nettype wire

// File: verif/tb_pkt_ingress.sv
`default_nettype none

module tb_pkt_ingress;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS = 16;
    localparam int MAX_ROWS  = 128;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        s_tvalid;
    logic        s_tready;
    logic        s_tstart;
    logic        s_tlast;
    logic [3:0]  s_tkeep;
    logic [7:0]  s_tuser;
    logic [31:0] s_tdata;
    logic        m_tvalid;
    logic        m_tready;
    logic        m_tlast;
    logic [3:0]  m_tkeep;
    logic [7:0]  m_tuser;
    logic [31:0] m_tdata;
    logic [15:0] pkt_count;
    logic [15:0] drop_count;

    logic [45:0] in_tab  [0:MAX_ROWS-1]; // start, last, keep, user, data
    logic [44:0] out_tab [0:MAX_ROWS-1]; // last, keep, user, data
    string       t_name  [0:MAX_TESTS-1];
    int          t_mode  [0:MAX_TESTS-1];
    int          t_in_lo [0:MAX_TESTS-1];
    int          t_in_n  [0:MAX_TESTS-1];
    int          t_out_lo[0:MAX_TESTS-1];
    int          t_out_n [0:MAX_TESTS-1];
    int          t_pkt   [0:MAX_TESTS-1];
    int          t_drop  [0:MAX_TESTS-1];
    int          num_tests   = 0;
    int          num_in      = 0;
    int          num_out     = 0;
    int          errors      = 0;
    int          failed      = 0;
    int          cycles      = 0;
    int          cycle_limit = 200;

    pkt_ingress_top #(
        .NUM_LEVELS (2),
        .MODE       (0),
        .MAX_BEATS  (4)
    ) DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .s_tstart   (s_tstart),
        .s_tlast    (s_tlast),
        .s_tkeep    (s_tkeep),
        .s_tuser    (s_tuser),
        .s_tdata    (s_tdata),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tlast    (m_tlast),
        .m_tkeep    (m_tkeep),
        .m_tuser    (m_tuser),
        .m_tdata    (m_tdata),
        .pkt_count  (pkt_count),
        .drop_count (drop_count)
    );

    always #20 clk = ~clk; // 40 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles, DUT stopped moving beats", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic load_cases();
        int                fd;
        int                code;
        int                a;
        int                b;
        logic [8*32-1:0]   word;
        logic [8*160-1:0]  rest;
        logic [31:0]       f0;
        logic [31:0]       f1;
        logic [31:0]       f2;
        logic [31:0]       f3;
        logic [31:0]       f4;
        fd = $fopen("verif/pkt_ingress_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file verif/pkt_ingress_cases.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", word) == 1) begin
                if (word == "#") begin
                    code = $fgets(rest, fd); // skip the comment text
                end else if (word == "T") begin
                    code = $fscanf(fd, "%s %d", word, a);
                    t_name[num_tests]   = string'(word);
                    t_mode[num_tests]   = a;
                    t_in_lo[num_tests]  = num_in;
                    t_out_lo[num_tests] = num_out;
                end else if (word == "I") begin
                    code = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    in_tab[num_in] = {f0[0], f1[0], f2[3:0], f3[7:0], f4};
                    num_in++;
                end else if (word == "O") begin
                    code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                    out_tab[num_out] = {f0[0], f1[3:0], f2[7:0], f3};
                    num_out++;
                end else if (word == "E") begin
                    code = $fscanf(fd, "%d %d", a, b);
                    t_pkt[num_tests]   = a;
                    t_drop[num_tests]  = b;
                    t_in_n[num_tests]  = num_in - t_in_lo[num_tests];
                    t_out_n[num_tests] = num_out - t_out_lo[num_tests];
                    num_tests++;
                end else begin
                    $display("unknown line tag in the cases file");
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t);
        int          in_idx;
        int          out_idx;
        int          quiet;
        int          test_cyc;
        int          errs_before;
        logic [15:0] pkt_base;
        logic [15:0] drop_base;
        logic        saw_full;
        logic [44:0] got;
        logic [44:0] exp_beat;
        errs_before = errors;
        pkt_base    = pkt_count;
        drop_base   = drop_count;
        in_idx      = 0;
        out_idx     = 0;
        quiet       = 0;
        test_cyc    = 0;
        saw_full    = 1'b0;
        while (quiet < 16) begin
            @(negedge clk);
            if (t_mode[t] == 1) begin
                m_tready = (test_cyc >= 20); // held off for 20 cycles and then released
            end else begin
                m_tready = ($urandom % 3) != 0;
            end
            if (in_idx < t_in_n[t]) begin
                s_tvalid = 1'b1;
                {s_tstart, s_tlast, s_tkeep, s_tuser, s_tdata} = in_tab[t_in_lo[t] + in_idx];
            end else begin
                s_tvalid = 1'b0;
            end
            #1; // let handshakes settle before sampling
            if (s_tvalid && s_tready) begin
                in_idx++;
            end
            if (s_tvalid && !s_tready) begin
                saw_full = 1'b1;
            end
            if (m_tvalid && m_tready) begin
                got = {m_tlast, m_tkeep, m_tuser, m_tdata};
                if (out_idx >= t_out_n[t]) begin
                    $display("%s: extra output beat %h that no case expects", t_name[t], got);
                    errors++;
                end else begin
                    exp_beat = out_tab[t_out_lo[t] + out_idx];
                    if (got !== exp_beat) begin
                        $write("[ERROR] %s beat %0d: expected last=%b keep=%h user=%h data=%h",
                               t_name[t], out_idx, exp_beat[44], exp_beat[43:40],
                               exp_beat[39:32], exp_beat[31:0]);
                        $display(", got last=%b keep=%h user=%h data=%h",
                                 got[44], got[43:40], got[39:32], got[31:0]);
                        errors++;
                    end
                end
                out_idx++;
                quiet = 0;
            end else if (in_idx >= t_in_n[t] && !m_tvalid) begin
                quiet++; // drained and watching for stragglers
            end
            test_cyc++;
        end
        if (out_idx < t_out_n[t]) begin
            $display("%s: missing output beats, got %0d of %0d", t_name[t], out_idx, t_out_n[t]);
            errors++;
        end
        if (pkt_count - pkt_base != 16'(t_pkt[t])) begin
            $display("[ERROR] %s pkt_count rise: expected %0d, got %0d",
                     t_name[t], t_pkt[t], pkt_count - pkt_base);
            errors++;
        end
        if (drop_count - drop_base != 16'(t_drop[t])) begin
            $display("[ERROR] %s drop_count rise: expected %0d, got %0d",
                     t_name[t], t_drop[t], drop_count - drop_base);
            errors++;
        end
        if (t_mode[t] == 1 && !saw_full) begin
            $display("%s: s_tready never fell while the output was stalled", t_name[t]);
            errors++;
        end
        if (errors == errs_before) begin
            $display("test %s: ok", t_name[t]);
        end else begin
            $display("test %s: FAILED with %0d errors", t_name[t], errors - errs_before);
            failed++;
        end
    endtask

    initial begin
        void'($urandom(40));
        arst_n   = 1'b0;
        s_tvalid = 1'b0;
        s_tstart = 1'b0;
        s_tlast  = 1'b0;
        s_tkeep  = '0;
        s_tuser  = '0;
        s_tdata  = '0;
        m_tready = 1'b0;
        load_cases();
        cycle_limit = 4 * num_in + 200;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests run: %0d, tests failed: %0d, errors: %0d", num_tests, failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hw/stream_pkg.sv
hw/stream_reg.sv
hw/beat_counter.sv
hw/frame_fsm.sv
hw/frame_gate.sv
hw/pkt_ingress_top.sv
verif/tb_pkt_ingress.sv

// File: verif/pkt_ingress_cases.txt
# test:     T <name> <stall mode, 0 random m_tready, 1 m_tready low for 20 cycles>
# beats:    I <start> <last> <keep> <user> <data>   O <last> <keep> <user> <data>   (hex)
# counters: E <pkt_count rise> <drop_count rise> closes the test
T pass_through 0
I 1 0 f 01 a0000001
I 0 0 f 01 a0000002
I 0 1 3 01 a0000003
I 1 1 1 02 a0000010
O 0 f 01 a0000001
O 0 f 01 a0000002
O 1 3 01 a0000003
O 1 1 02 a0000010
E 2 0
T orphan_drop 0
I 0 0 f 10 b0000001
I 0 1 f 10 b0000002
I 1 0 f 11 b0000003
I 0 1 7 11 b0000004
O 0 f 11 b0000003
O 1 7 11 b0000004
E 1 2
T cut_long 0
I 1 0 f 20 c0000001
I 0 0 f 20 c0000002
I 0 0 f 20 c0000003
I 0 0 3 20 c0000004
I 0 0 f 20 c0000005
I 0 1 1 20 c0000006
O 0 f 20 c0000001
O 0 f 20 c0000002
O 0 f 20 c0000003
O 1 f 20 c0000004
E 1 2
T restart_no_last 0
I 1 0 f 30 d0000001
I 0 0 f 30 d0000002
I 1 0 f 31 d0000011
I 0 0 f 31 d0000012
I 0 0 f 31 d0000013
I 0 1 f 31 d0000014
O 0 f 30 d0000001
O 0 f 30 d0000002
O 0 f 31 d0000011
O 0 f 31 d0000012
O 0 f 31 d0000013
O 1 f 31 d0000014
E 1 0
T back_pressure 1
I 1 0 f 40 f0000001
I 0 1 f 40 f0000002
I 1 0 f 41 f0000003
I 0 1 f 41 f0000004
I 1 0 f 42 f0000005
I 0 1 f 42 f0000006
I 1 0 f 43 f0000007
I 0 1 f 43 f0000008
O 0 f 40 f0000001
O 1 f 40 f0000002
O 0 f 41 f0000003
O 1 f 41 f0000004
O 0 f 42 f0000005
O 1 f 42 f0000006
O 0 f 43 f0000007
O 1 f 43 f0000008
E 4 0
T mixed_random 0
I 0 1 f 50 e0000001
I 1 0 f 51 e0000002
I 0 0 f 51 e0000003
I 0 0 f 51 e0000004
I 0 0 f 51 e0000005
I 0 1 f 51 e0000006
I 1 1 5 52 e0000007
O 0 f 51 e0000002
O 0 f 51 e0000003
O 0 f 51 e0000004
O 1 f 51 e0000005
O 1 5 52 e0000007
E 2 2
